// ==== files.f ====
logic/mem_pkg.sv
logic/avl_if.sv
logic/avl_bridge.sv
logic/avl_decoder.sv
logic/avl_ram.sv
logic/avl_gpio.sv
logic/avl_mem_sys.sv
verif/avl_mem_sys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= avl_mem_sys_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the binary exits with a failing status when the testbench calls $fatal.
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/avl_mem_sys_tb.sv ====
`timescale 1ns/1ps

module avl_mem_sys_tb;
  import mem_pkg::*;

  localparam int ram_words = 256;
  localparam int ram_wait  = 2;
  localparam int max_wait  = 50; // cycles allowed for any single wait.
  localparam int word_bits = $clog2(ram_words);

  typedef enum {op_read, op_write, op_pins} op_t;

  typedef struct {
    string name;
    op_t   op;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
    data_t exp_rdata;
    int    exp_lat;
    data_t exp_gpio; // gpio_out once the step is done.
  } step_t;

  logic   clk;
  logic   rst;
  logic   valid;
  addr_t  addr;
  data_t  wdata;
  strb_t  wstrb;
  data_t  rdata;
  logic   ready;
  data_t  gpio_in;
  data_t  gpio_out;

  step_t  steps[$];
  data_t  ref_ram [ram_words];
  data_t  ref_out;
  data_t  ref_pins;
  addr_t  rand_addrs[$];
  integer seed;

  avl_mem_sys #(
    .ram_words (ram_words),
    .ram_wait  (ram_wait)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .valid    (valid),
    .addr     (addr),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .rdata    (rdata),
    .ready    (ready),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  function automatic bit in_ram(addr_t a);
    return (a[31:28] == region_ram) && ({2'b00, a[31:2]} < ram_words);
  endfunction

  // word index of an address already known to lie inside the RAM.
  function automatic logic [word_bits-1:0] word_of(addr_t a);
    return a[word_bits+1:2];
  endfunction

  function automatic void add_write(string name, addr_t a, data_t d, strb_t s);
    step_t st;
    st = '{name, op_write, a, d, s, '0, 1, '0};
    if (in_ram(a)) begin
      ref_ram[word_of(a)] = merge_bytes(ref_ram[word_of(a)], d, s);
      st.exp_lat = ram_wait + 1;
    end else if (a[31:28] == region_gpio && a[27:0] == gpio_out_off[27:0]) begin
      ref_out = merge_bytes(ref_out, d, s);
    end
    st.exp_gpio = ref_out;
    steps.push_back(st);
  endfunction

  function automatic void add_read(string name, addr_t a);
    step_t st;
    st = '{name, op_read, a, '0, 4'h0, '0, 1, '0};
    if (in_ram(a)) begin
      st.exp_rdata = ref_ram[word_of(a)];
      st.exp_lat   = ram_wait + 1;
    end else if (a[31:28] == region_gpio && a[27:0] == gpio_out_off[27:0]) begin
      st.exp_rdata = ref_out;
    end else if (a[31:28] == region_gpio && a[27:0] == gpio_in_off[27:0]) begin
      st.exp_rdata = ref_pins;
    end
    st.exp_gpio = ref_out;
    steps.push_back(st);
  endfunction

  function automatic void add_pins(string name, data_t v);
    ref_pins = v;
    steps.push_back('{name, op_pins, '0, v, 4'h0, '0, 0, ref_out});
  endfunction

  task automatic check_word(string name, data_t exp, data_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_cycles(string name, int exp, int act);
    if (exp != act) begin
      $display("CHECK FAILED %s: expected %0d cycles, actual %0d cycles", name, exp, act);
      $display("Verification failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // one valid pulse, then ready is sampled at each falling edge.
  task automatic run_transfer(step_t st, output data_t rd, output int lat);
    @(posedge clk);
    valid <= 1'b1;
    addr  <= st.addr;
    wdata <= st.wdata;
    wstrb <= st.wstrb;
    @(posedge clk);
    valid <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      if (lat > max_wait) begin
        $display("timeout: %s got no ready within %0d cycles", st.name, max_wait);
        $display("Verification failed");
        $fatal(1, "transfer never finished");
      end
    end while (!ready);
    rd = rdata;
  endtask

  initial begin
    data_t rd;
    int    lat;
    addr_t a;
    valid   = 1'b0;
    addr    = '0;
    wdata   = '0;
    wstrb   = '0;
    gpio_in = '0;
    rst     = 1'b0;
    seed    = 32'hbce4;
    ref_out  = '0;
    ref_pins = '0;

    add_write("ram full write", 32'h0000_0010, 32'hdead_beef, 4'hf);
    add_read("ram full read", 32'h0000_0010);
    add_write("ram base word", 32'h0000_0020, 32'h1122_3344, 4'hf);
    add_write("ram low half", 32'h0000_0020, 32'haabb_ccdd, 4'b0011);
    add_write("ram top byte", 32'h0000_0020, 32'h5566_7788, 4'b1000);
    add_read("ram merged read", 32'h0000_0020);
    for (int i = 0; i < 16; i++) begin
      a = ($unsigned($random(seed)) % ram_words) * 4;
      rand_addrs.push_back(a);
      add_write($sformatf("random write %0d", i), a, $random(seed), 4'hf);
    end
    foreach (rand_addrs[i]) add_read($sformatf("random read %0d", i), rand_addrs[i]);
    add_write("gpio out full", 32'h1000_0000, 32'h0f0f_0f0f, 4'hf);
    add_write("gpio out merge", 32'h1000_0000, 32'ha5a5_a5a5, 4'b0101);
    add_read("gpio out read", 32'h1000_0000);
    add_pins("gpio in set", 32'h1357_9bdf);
    add_read("gpio in read", 32'h1000_0004);
    add_write("ram word 0", 32'h0000_0000, 32'h0bad_f00d, 4'hf);
    add_read("unmapped past ram", 32'h0000_0400);
    add_read("unmapped region", 32'h2000_0040);
    add_write("unmapped alias write", 32'h0000_0400, 32'hffff_ffff, 4'hf); // would hit word 0.
    add_write("unmapped region write", 32'h2000_0000, 32'hffff_ffff, 4'hf);
    add_read("ram word 0 intact", 32'h0000_0000);

    repeat (3) @(posedge clk);
    rst <= 1'b1;

    foreach (steps[i]) begin
      if (steps[i].op == op_pins) begin
        @(posedge clk);
        gpio_in <= steps[i].wdata;
        repeat (4) @(posedge clk); // held well past the two synchronizer flops.
      end else begin
        run_transfer(steps[i], rd, lat);
        check_cycles({steps[i].name, " latency"}, steps[i].exp_lat, lat);
        check_word({steps[i].name, " rdata"}, steps[i].exp_rdata, rd);
      end
      @(negedge clk);
      check_word({steps[i].name, " gpio_out"}, steps[i].exp_gpio, gpio_out);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== logic/avl_mem_sys.sv ====
`timescale 1ns/1ps

module avl_mem_sys #(
  parameter int ram_words = 256,
  parameter int ram_wait  = 2
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           valid,
  input  mem_pkg::addr_t addr,
  input  mem_pkg::data_t wdata,
  input  mem_pkg::strb_t wstrb,
  output mem_pkg::data_t rdata,
  output logic           ready,
  input  mem_pkg::data_t gpio_in,
  output mem_pkg::data_t gpio_out
);

  avl_if bus_m ();
  avl_if bus_ram ();
  avl_if bus_gpio ();

  avl_bridge bridge0 (
    .clk   (clk),
    .rst   (rst),
    .valid (valid),
    .addr  (addr),
    .wdata (wdata),
    .wstrb (wstrb),
    .rdata (rdata),
    .ready (ready),
    .bus   (bus_m.master)
  );

  avl_decoder #(
    .ram_words (ram_words)
  ) decoder0 (
    .m    (bus_m.slave),
    .ram  (bus_ram.master),
    .gpio (bus_gpio.master)
  );

  avl_ram #(
    .ram_words (ram_words),
    .ram_wait  (ram_wait)
  ) ram0 (
    .clk (clk),
    .rst (rst),
    .bus (bus_ram.slave)
  );

  avl_gpio gpio0 (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus_gpio.slave),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

endmodule

// ==== logic/avl_gpio.sv ====
`timescale 1ns/1ps

module avl_gpio (
  input  logic           clk,
  input  logic           rst,
  avl_if.slave           bus,
  input  mem_pkg::data_t gpio_in,
  output mem_pkg::data_t gpio_out
);
  import mem_pkg::*;

  data_t out_q;
  data_t in_meta;
  data_t in_sync;
  logic  sel_out;
  logic  sel_in;

  assign sel_out = (bus.address[27:0] == gpio_out_off[27:0]);
  assign sel_in  = (bus.address[27:0] == gpio_in_off[27:0]);

  always_ff @(posedge clk) begin
    if (!rst) begin
      out_q <= '0;
    end else if (bus.write && sel_out) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.byteenable[b]) begin
          out_q[8*b +: 8] <= bus.writedata[8*b +: 8];
        end
      end
    end
  end

  // gpio_in is asynchronous to clk.
  always_ff @(posedge clk) begin
    in_meta <= gpio_in;
    in_sync <= in_meta;
  end

  always_comb begin
    if (sel_out) begin
      bus.readdata = out_q;
    end else if (sel_in) begin
      bus.readdata = in_sync;
    end else begin
      bus.readdata = '0; // other offsets read as zero.
    end
  end

  assign bus.waitrequest   = 1'b0;
  assign bus.readdatavalid = bus.read;
  assign gpio_out          = out_q;

endmodule

// ==== logic/avl_ram.sv ====
`timescale 1ns/1ps

module avl_ram #(
  parameter int ram_words = 256,
  parameter int ram_wait  = 2
) (
  input  logic clk,
  input  logic rst,
  avl_if.slave bus
);
  import mem_pkg::*;

  localparam int aw = $clog2(ram_words);
  localparam int cw = $clog2(ram_wait + 2);

  data_t          mem [ram_words];
  logic [aw-1:0]  idx;
  logic [cw-1:0]  cnt;
  logic           req;
  logic           done;

  assign idx  = bus.address[aw+1:2];
  assign req  = bus.read | bus.write;
  // one address cycle, then ram_wait cycles of the held request.
  assign done = (cnt == cw'(ram_wait + 1));

  always_ff @(posedge clk) begin
    if (!rst) begin
      cnt <= '0;
    end else if (!req || done) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.write && done) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.byteenable[b]) begin
          mem[idx][8*b +: 8] <= bus.writedata[8*b +: 8];
        end
      end
    end
  end

  assign bus.waitrequest   = req & ~done;
  assign bus.readdatavalid = bus.read & done;
  assign bus.readdata      = (bus.read && done) ? mem[idx] : '0;

  // the decoder must keep out of range addresses away from the array.
  a_in_range: assert property (@(posedge clk) disable iff (!rst)
    req |-> bus.address[31:2] < 30'(ram_words));

endmodule

// ==== logic/avl_decoder.sv ====
`timescale 1ns/1ps

module avl_decoder #(
  parameter int ram_words = 256
) (
  avl_if.slave  m,
  avl_if.master ram,
  avl_if.master gpio
);
  import mem_pkg::*;

  logic [3:0] region;
  logic       ram_sel;
  logic       gpio_sel;

  assign region   = m.address[31:28];
  assign ram_sel  = (region == region_ram) && (m.address[27:2] < 26'(ram_words));
  assign gpio_sel = (region == region_gpio);

  assign ram.address     = m.address;
  assign ram.byteenable  = m.byteenable;
  assign ram.writedata   = m.writedata;
  assign ram.read        = m.read & ram_sel;
  assign ram.write       = m.write & ram_sel;

  assign gpio.address    = m.address;
  assign gpio.byteenable = m.byteenable;
  assign gpio.writedata  = m.writedata;
  assign gpio.read       = m.read & gpio_sel;
  assign gpio.write      = m.write & gpio_sel;

  always_comb begin
    if (ram_sel) begin
      m.readdata      = ram.readdata;
      m.waitrequest   = ram.waitrequest;
      m.readdatavalid = ram.readdatavalid;
    end else if (gpio_sel) begin
      m.readdata      = gpio.readdata;
      m.waitrequest   = gpio.waitrequest;
      m.readdatavalid = gpio.readdatavalid;
    end else begin
      // unmapped space answers at once with zero, and writes are dropped.
      m.readdata      = '0;
      m.waitrequest   = 1'b0;
      m.readdatavalid = m.read;
    end
  end

endmodule

// ==== logic/avl_bridge.sv ====
`timescale 1ns/1ps

module avl_bridge (
  input  logic           clk,
  input  logic           rst,
  input  logic           valid,
  input  mem_pkg::addr_t addr,
  input  mem_pkg::data_t wdata,
  input  mem_pkg::strb_t wstrb,
  output mem_pkg::data_t rdata,
  output logic           ready,
  avl_if.master          bus
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    idle,
    load,
    store
  } state_t;

  state_t state;
  state_t state_next;
  addr_t  addr_q;
  data_t  wdata_q;
  strb_t  wstrb_q;
  logic   start_rd;
  logic   start_wr;

  assign start_rd = valid & ~(|wstrb); // an empty strobe mask means a read.
  assign start_wr = valid & (|wstrb);

  // the request goes out straight from the core port in the valid cycle.
  // After that the registered copy is held until the slave stops waiting.
  always_comb begin
    if (state == idle) begin
      bus.address    = addr;
      bus.byteenable = wstrb;
      bus.writedata  = wdata;
      bus.read       = start_rd;
      bus.write      = start_wr;
    end else begin
      bus.address    = addr_q;
      bus.byteenable = wstrb_q;
      bus.writedata  = wdata_q;
      bus.read       = (state == load);
      bus.write      = (state == store);
    end
  end

  always_comb begin
    state_next = state;
    ready      = 1'b0;
    rdata      = '0;
    case (state)
      idle: begin
        if (start_rd) begin
          state_next = load;
        end else if (start_wr) begin
          state_next = store;
        end
      end
      load: begin
        if (!bus.waitrequest && bus.readdatavalid) begin
          state_next = idle;
          ready      = 1'b1;
          rdata      = bus.readdata;
        end
      end
      store: begin
        if (!bus.waitrequest) begin
          state_next = idle;
          ready      = 1'b1;
        end
      end
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && valid) begin
      addr_q  <= addr;
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
  end

  // the core may start a transfer only while the bridge is idle.
  a_valid_idle: assert property (@(posedge clk) disable iff (!rst)
    valid |-> state == idle);

  // a write is never answered with read data.
  a_wr_no_rdvalid: assert property (@(posedge clk) disable iff (!rst)
    bus.write |-> !bus.readdatavalid);

endmodule

// ==== logic/avl_if.sv ====
`timescale 1ns/1ps

interface avl_if;
  import mem_pkg::*;

  addr_t address;
  strb_t byteenable;
  logic  read;
  logic  write;
  data_t writedata;
  data_t readdata;
  logic  waitrequest;
  logic  readdatavalid; // comes in the same cycle that waitrequest is low.

  modport master (
    output address,
    output byteenable,
    output read,
    output write,
    output writedata,
    input  readdata,
    input  waitrequest,
    input  readdatavalid
  );

  modport slave (
    input  address,
    input  byteenable,
    input  read,
    input  write,
    input  writedata,
    output readdata,
    output waitrequest,
    output readdatavalid
  );

endinterface

// ==== logic/mem_pkg.sv ====
package mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // the region is taken from the top four address bits.
  localparam logic [3:0] region_ram  = 4'd0;
  localparam logic [3:0] region_gpio = 4'd1;

  // byte offsets inside the GPIO region.
  localparam addr_t gpio_out_off = 32'h0000_0000;
  localparam addr_t gpio_in_off  = 32'h0000_0004;

endpackage
